// ==== filelist.f ====
+incdir+src
src/fetch_pkg.sv
src/fetch_if.sv
src/fetch_pc_gen.sv
src/fetch_lane.sv
src/fetch_bundle_queue.sv
src/fetch_top.sv
dv/fetch_properties.sv
dv/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the fetch front-end testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module fetch_tb \
    -Mdir obj_dir > build.log 2>&1 &&
./obj_dir/Vfetch_tb > sim.log 2>&1 ||
{ echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }
grep -q "=== FAIL ===" sim.log &&
{ echo "Simulation reported failure, see sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log ||
{ echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0

// ==== dv/fetch_tb.sv ====
// Testbench for the fetch front end
// Clock, reset, cache model, xorshift stalls, reference bundle queue,
// directed tests, timeout and summary

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_tb import fetch_pkg::*; ();

    // Reset and rough per-test cycle budgets
    // Timeout at twice the sum
    localparam int TEST_CYCLES = 16 + 16 + 56 + 10 + 14 + 22;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                     clock;
    logic                     reset;
    logic                     icache_valid_i;
    window_t                  icache_data_i;
    addr_t                    imem_addr_o;
    logic                     pred_valid_i;
    logic                     pred_taken_i;
    lane_idx_t                pred_lane_i;
    addr_t                    pred_target_i;
    logic                     redirect_valid_i;
    addr_t                    redirect_pc_i;
    logic                     dispatch_ready_i;
    logic                     bundle_valid_o;
    lane_mask_t               bundle_mask_o;
    addr_t [`FETCH_WIDTH-1:0] bundle_pc_o;
    inst_t [`FETCH_WIDTH-1:0] bundle_inst_o;

    // Stimulus for the next cycle, set by the tests
    logic      pred_v;
    lane_idx_t pred_lane;
    addr_t     pred_target;
    logic      redir_v;
    addr_t     redir_pc;

    // Reference model state
    addr_t      exp_pc;
    addr_t      ref_base [$];
    lane_mask_t ref_mask [$];
    logic [31:0] rng_state;
    int          check_count;
    int          error_count;
    int          test_start_errors;
    int          cycle_count;

    fetch_top UUT (
        .clock            (clock),
        .reset            (reset),
        .icache_valid_i   (icache_valid_i),
        .icache_data_i    (icache_data_i),
        .imem_addr_o      (imem_addr_o),
        .pred_valid_i     (pred_valid_i),
        .pred_taken_i     (pred_taken_i),
        .pred_lane_i      (pred_lane_i),
        .pred_target_i    (pred_target_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .dispatch_ready_i (dispatch_ready_i),
        .bundle_valid_o   (bundle_valid_o),
        .bundle_mask_o    (bundle_mask_o),
        .bundle_pc_o      (bundle_pc_o),
        .bundle_inst_o    (bundle_inst_o)
    );

    always #20 clock = ~clock;

    // --------------------------------------------------
    // Models and helpers
    // --------------------------------------------------

    // Memory image with every word tagged by its own address
    function automatic inst_t model_word(input addr_t a);
        return 32'hC000_0000 | a;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lanes 0 up to the predicted lane survive
    function automatic lane_mask_t cut_mask(input lane_idx_t last);
        lane_mask_t m;
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
            m[k] = (k <= 32'(last));
        end
        return m;
    endfunction

    // Same-cycle cache with the window starting at the aligned block
    always_comb begin
        for (int b = 0; b < `WINDOW_BLOCKS; b++) begin
            icache_data_i[b] = {model_word(imem_addr_o + addr_t'(8 * b + 4)),
                                model_word(imem_addr_o + addr_t'(8 * b))};
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    // One falling-edge cycle checked against the reference queue
    task automatic drive_cycle(input logic cache_v, input logic ready);
        logic       fire;
        addr_t      head;
        lane_mask_t hmask;
        addr_t      lane_pc;
        inst_t      lane_inst;
        @(negedge clock);
        icache_valid_i   = cache_v;
        dispatch_ready_i = ready;
        pred_valid_i     = pred_v;
        pred_taken_i     = pred_v;
        pred_lane_i      = pred_lane;
        pred_target_i    = pred_target;
        redirect_valid_i = redir_v;
        redirect_pc_i    = redir_pc;
        // Outputs settled since the last rising edge
        check_value("imem_addr_o", imem_addr_o, {exp_pc[`ADDR_WIDTH-1:3], 3'b000});
        check_value("bundle_valid_o", 32'(bundle_valid_o), 32'(ref_base.size() != 0));
        fire = cache_v && !redir_v && (ref_base.size() < `QUEUE_DEPTH);
        if (redir_v) begin
            ref_base.delete();
            ref_mask.delete();
            exp_pc = redir_pc;
        end else begin
            if (ready && ref_base.size() != 0) begin
                head  = ref_base.pop_front();
                hmask = ref_mask.pop_front();
                check_value("bundle_mask_o", 32'(bundle_mask_o), 32'(hmask));
                for (int k = 0; k < `FETCH_WIDTH; k++) begin
                    lane_pc   = head + addr_t'(4 * k);
                    lane_inst = hmask[k] ? model_word(lane_pc) : `NOP;
                    if (hmask[k]) begin
                        check_value($sformatf("bundle_pc_o[%0d]", k), bundle_pc_o[k], lane_pc);
                    end
                    check_value($sformatf("bundle_inst_o[%0d]", k), bundle_inst_o[k],
                                lane_inst);
                end
            end else if (ref_base.size() == 0) begin
                check_value("bundle_mask_o", 32'(bundle_mask_o), 32'h0);
            end
            if (fire) begin
                ref_base.push_back(exp_pc);
                ref_mask.push_back(pred_v ? cut_mask(pred_lane) : '1);
                exp_pc = pred_v ? pred_target : exp_pc + addr_t'(4 * `FETCH_WIDTH);
            end
        end
    endtask

    task automatic drain_queue();
        while (ref_base.size() != 0) begin
            drive_cycle(1'b0, 1'b1);
        end
        drive_cycle(1'b0, 1'b1);
    endtask

    task automatic report_test(input string name);
        $display("%s done, %0d errors", name, error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_sequential();
        repeat (12) drive_cycle(1'b1, 1'b1);
        drain_queue();
        report_test("sequential fetch");
    endtask

    // Misses and dispatch stalls from the xorshift stream
    task automatic test_random_stall();
        repeat (48) begin
            rng_state = xorshift32(rng_state);
            drive_cycle(rng_state[1:0] != 2'b00, rng_state[5:4] != 2'b00);
        end
        drain_queue();
        report_test("random stalls");
    endtask

    // Taken on lane 0 to an unaligned target
    task automatic test_taken_branch();
        pred_v      = 1'b1;
        pred_lane   = '0;
        pred_target = 32'h0000_0104;
        drive_cycle(1'b1, 1'b1);
        pred_v = 1'b0;
        repeat (4) drive_cycle(1'b1, 1'b1);
        drain_queue();
        report_test("taken branch");
    endtask

    // Queue partly filled, then flushed
    task automatic test_redirect();
        repeat (3) drive_cycle(1'b1, 1'b0);
        redir_v  = 1'b1;
        redir_pc = 32'h0000_0200;
        drive_cycle(1'b1, 1'b0);
        redir_v = 1'b0;
        repeat (6) drive_cycle(1'b1, 1'b1);
        drain_queue();
        report_test("redirect flush");
    endtask

    // Fill to depth, fetch must hold, then release
    task automatic test_backpressure();
        addr_t start_pc;
        start_pc = exp_pc;
        repeat (8) drive_cycle(1'b1, 1'b0);
        // Fetch stops exactly QUEUE_DEPTH bundles past the start
        check_value("imem_addr_o",
                    imem_addr_o,
                    (start_pc + addr_t'(4 * `FETCH_WIDTH * `QUEUE_DEPTH)) & ~addr_t'(7));
        repeat (8) drive_cycle(1'b1, 1'b1);
        drain_queue();
        report_test("back-pressure");
    endtask

    // --------------------------------------------------
    // Main sequence and timeout
    // --------------------------------------------------

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        clock             = 1'b0;
        reset             = 1'b1;
        icache_valid_i    = 1'b0;
        pred_valid_i      = 1'b0;
        pred_taken_i      = 1'b0;
        pred_lane_i       = '0;
        pred_target_i     = '0;
        redirect_valid_i  = 1'b0;
        redirect_pc_i     = '0;
        dispatch_ready_i  = 1'b0;
        pred_v            = 1'b0;
        pred_lane         = '0;
        pred_target       = '0;
        redir_v           = 1'b0;
        redir_pc          = '0;
        exp_pc            = `RESET_PC;
        rng_state         = 32'd61399;
        check_count       = 0;
        error_count       = 0;
        test_start_errors = 0;
        cycle_count       = 0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        test_sequential();
        test_random_stall();
        test_taken_branch();
        test_redirect();
        test_backpressure();
        // Failed assertions of the bound checker count as errors
        error_count += UUT.u_properties.fail_count;
        $display("Summary %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/fetch_properties.sv ====
// Concurrent checks on the fetch front end, bound to fetch_top
// Contiguous bundle mask, cache address held on a stall, empty queue after redirect

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_properties import fetch_pkg::*; (
    input wire logic       clock,
    input wire logic       reset,
    input wire logic       icache_valid_i,
    input wire logic       queue_full_i,
    input wire logic       redirect_valid_i,
    input wire addr_t      imem_addr_o,
    input wire logic       bundle_valid_o,
    input wire lane_mask_t bundle_mask_o
);

    // Failed assertions so far
    int fail_count = 0;

    // Valid lanes start at lane 0 with no gaps
    mask_contiguous: assert property (@(posedge clock) disable iff (reset)
        bundle_valid_o |-> (bundle_mask_o[0] &&
        ((bundle_mask_o & lane_mask_t'(bundle_mask_o + lane_mask_t'(1))) == '0)))
        else begin
            fail_count++;
            $error("bundle mask has a gap or misses lane 0");
        end

    // Miss or full queue without a redirect keeps the fetch block
    addr_holds: assert property (@(posedge clock) disable iff (reset)
        (!redirect_valid_i && (!icache_valid_i || queue_full_i)) |=> $stable(imem_addr_o))
        else begin
            fail_count++;
            $error("cache address moved although no bundle was taken");
        end

    // Flush leaves nothing to dispatch
    flush_empties: assert property (@(posedge clock) disable iff (reset)
        redirect_valid_i |=> !bundle_valid_o)
        else begin
            fail_count++;
            $error("bundle still valid after a redirect");
        end

endmodule

bind fetch_top fetch_properties u_properties (
    .clock            (clock),
    .reset            (reset),
    .icache_valid_i   (icache_valid_i),
    .queue_full_i     (queue_full),
    .redirect_valid_i (redirect_valid_i),
    .imem_addr_o      (imem_addr_o),
    .bundle_valid_o   (bundle_valid_o),
    .bundle_mask_o    (bundle_mask_o)
);

`default_nettype wire

// ==== src/fetch_top.sv ====
// Fetch front-end top level
// PC generator, one fetch lane per bundle slot, bundle queue

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_top import fetch_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    // Instruction cache
    input  logic                        icache_valid_i,
    input  window_t                     icache_data_i,
    output addr_t                       imem_addr_o,
    // Branch predictor
    input  logic                        pred_valid_i,
    input  logic                        pred_taken_i,
    input  lane_idx_t                   pred_lane_i,
    input  addr_t                       pred_target_i,
    // Execute-stage redirect
    input  logic                        redirect_valid_i,
    input  addr_t                       redirect_pc_i,
    // Dispatch side
    input  logic                        dispatch_ready_i,
    output logic                        bundle_valid_o,
    output lane_mask_t                  bundle_mask_o,
    output addr_t [`FETCH_WIDTH-1:0]    bundle_pc_o,
    output inst_t [`FETCH_WIDTH-1:0]    bundle_inst_o
);

    fetch_ctl_if  ctl_bus ();
    fetch_lane_if lane_bus [`FETCH_WIDTH] ();

    logic queue_full;

    fetch_pc_gen u_pc_gen (
        .clock            (clock),
        .reset            (reset),
        .icache_valid_i   (icache_valid_i),
        .icache_data_i    (icache_data_i),
        .pred_valid_i     (pred_valid_i),
        .pred_taken_i     (pred_taken_i),
        .pred_lane_i      (pred_lane_i),
        .pred_target_i    (pred_target_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .queue_full_i     (queue_full),
        .imem_addr_o      (imem_addr_o),
        .ctl              (ctl_bus.gen)
    );

    // One lane per bundle slot
    genvar k;
    for (k = 0; k < `FETCH_WIDTH; k++) begin : g_lane
        fetch_lane #(
            .LANE (k)
        ) u_lane (
            .ctl (ctl_bus.lane),
            .out (lane_bus[k].lane)
        );
    end

    // Redirect flushes anything fetched down the wrong path
    fetch_bundle_queue u_queue (
        .clock   (clock),
        .reset   (reset),
        .lanes   (lane_bus),
        .flush_i (redirect_valid_i),
        .pop_i   (dispatch_ready_i),
        .full_o  (queue_full),
        .valid_o (bundle_valid_o),
        .mask_o  (bundle_mask_o),
        .pc_o    (bundle_pc_o),
        .inst_o  (bundle_inst_o)
    );

endmodule

`default_nettype wire

// ==== src/fetch_bundle_queue.sv ====
// Bundle queue between fetch and dispatch
// Circular buffer of whole bundles with count, registered full,
// dispatch pop and redirect flush

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_bundle_queue import fetch_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    fetch_lane_if.queue                 lanes [`FETCH_WIDTH],
    input  logic                        flush_i,
    input  logic                        pop_i,
    output logic                        full_o,
    output logic                        valid_o,
    output lane_mask_t                  mask_o,
    output addr_t [`FETCH_WIDTH-1:0]    pc_o,
    output inst_t [`FETCH_WIDTH-1:0]    inst_o
);

    localparam int unsigned DEPTH = `QUEUE_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   count_t;

    // Lane packets gathered into one bundle
    lane_mask_t                in_mask;
    addr_t [`FETCH_WIDTH-1:0]  in_pc;
    inst_t [`FETCH_WIDTH-1:0]  in_inst;

    // Bundle storage
    lane_mask_t                mask_mem [DEPTH];
    addr_t [`FETCH_WIDTH-1:0]  pc_mem   [DEPTH];
    inst_t [`FETCH_WIDTH-1:0]  inst_mem [DEPTH];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;
    count_t count_d;
    logic   full_q;
    logic   push;
    logic   pop_ok;

    genvar k;
    for (k = 0; k < `FETCH_WIDTH; k++) begin : g_gather
        assign in_mask[k] = lanes[k].valid;
        assign in_pc[k]   = lanes[k].pc;
        assign in_inst[k] = lanes[k].inst;
    end

    // --------------------------------------------------
    // Push, pop and occupancy
    // --------------------------------------------------

    // Pop on an empty queue is ignored
    assign pop_ok = pop_i && (count != '0);

    // A full queue still takes a bundle when the head leaves
    assign push = (|in_mask) && (!full_q || pop_ok) && !flush_i;

    always_comb begin
        count_d = count;
        if (push && !pop_ok) begin
            count_d = count + count_t'(1);
        end else if (!push && pop_ok) begin
            count_d = count - count_t'(1);
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full_q <= 1'b0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            count  <= count_d;
            full_q <= (count_d == count_t'(DEPTH));
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mask_mem[wr_ptr] <= in_mask;
            pc_mem[wr_ptr]   <= in_pc;
            inst_mem[wr_ptr] <= in_inst;
        end
    end

    // --------------------------------------------------
    // Head entry
    // --------------------------------------------------

    assign full_o  = full_q;
    assign valid_o = (count != '0);
    assign mask_o  = valid_o ? mask_mem[rd_ptr] : '0;
    assign pc_o    = pc_mem[rd_ptr];
    assign inst_o  = inst_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== src/fetch_lane.sv ====
// One fetch lane
// Word select from the cache window, lane PC and NPC, lane valid under a cut

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_lane import fetch_pkg::*; #(
    parameter int unsigned LANE = 0
) (
    fetch_ctl_if.lane  ctl,
    fetch_lane_if.lane out
);

    // Window seen as a flat run of 32-bit words
    localparam int unsigned WORDS      = 2 * `WINDOW_BLOCKS;
    localparam int unsigned WORD_IDX_W = $clog2(WORDS);

    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    logic [WORDS*32-1:0] flat_words;
    word_idx_t           word_idx;
    inst_t               picked;
    logic                beyond_cut;

    assign flat_words = ctl.window;

    // Offset of the first word inside block 0, plus this lane
    assign word_idx = word_idx_t'(ctl.base_pc[2]) + word_idx_t'(LANE);

    // Unaligned bundles spill into the next block
    assign picked = flat_words[word_idx*32 +: 32];

    // --------------------------------------------------
    // Lane packet
    // --------------------------------------------------

    assign out.pc  = ctl.base_pc + addr_t'(4 * LANE);
    assign out.npc = out.pc + addr_t'(4);

    // Lanes past the predicted branch are dropped
    assign beyond_cut = ctl.cut && (lane_idx_t'(LANE) > ctl.cut_lane);

    assign out.valid = ctl.fire && !beyond_cut;

    // NOP on a dead lane keeps the queue payload clean
    assign out.inst = out.valid ? picked : `NOP;

endmodule

`default_nettype wire

// ==== src/fetch_pc_gen.sv ====
// Fetch PC generator
// PC register, next-PC priority, fire decision and aligned cache address

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_pc_gen import fetch_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    // Instruction cache response
    input  logic       icache_valid_i,
    input  window_t    icache_data_i,
    // Branch prediction for the current bundle
    input  logic       pred_valid_i,
    input  logic       pred_taken_i,
    input  lane_idx_t  pred_lane_i,
    input  addr_t      pred_target_i,
    // Execute-stage correction
    input  logic       redirect_valid_i,
    input  addr_t      redirect_pc_i,
    // Back-pressure from the bundle queue
    input  logic       queue_full_i,
    output addr_t      imem_addr_o,
    fetch_ctl_if.gen   ctl
);

    // Sequential advance, 4 bytes per lane
    localparam addr_t PC_STEP = addr_t'(4 * `FETCH_WIDTH);

    addr_t pc_q;
    addr_t pc_d;
    logic  fire;
    logic  taken;

    // --------------------------------------------------
    // Fire and prediction
    // --------------------------------------------------

    // Whole bundle goes or nothing does
    // A miss, a redirect or a full queue stalls it
    assign fire  = icache_valid_i && !redirect_valid_i && !queue_full_i;

    // Prediction applies to the bundle on the cache bus now
    assign taken = pred_valid_i && pred_taken_i;

    // --------------------------------------------------
    // Next PC
    // --------------------------------------------------

    // Redirect first, then predicted taken, then sequential
    always_comb begin
        pc_d = pc_q;
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (fire) begin
            if (taken) begin
                pc_d = pred_target_i;
            end else begin
                pc_d = pc_q + PC_STEP;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // Cache address on a 64-bit block boundary
    assign imem_addr_o = {pc_q[`ADDR_WIDTH-1:3], 3'b000};

    // --------------------------------------------------
    // Lane control
    // --------------------------------------------------

    assign ctl.base_pc  = pc_q;
    assign ctl.fire     = fire;
    assign ctl.cut      = taken;
    assign ctl.cut_lane = pred_lane_i;
    assign ctl.window   = icache_data_i;

endmodule

`default_nettype wire

// ==== src/fetch_if.sv ====
// Fetch front-end interfaces
// fetch_ctl_if carries PC generator control and cache data to the lanes
// fetch_lane_if carries one lane's packet to the bundle queue

`timescale 1ns/1ps
`default_nettype none

interface fetch_ctl_if import fetch_pkg::*; ();

    // Current fetch PC
    addr_t   base_pc;
    // Bundle accepted this cycle
    logic    fire;
    // Taken prediction cuts the bundle
    logic    cut;
    // Last lane kept under a cut
    lane_idx_t cut_lane;
    // Cache window for this PC
    window_t window;

    modport gen  (output base_pc, fire, cut, cut_lane, window);
    modport lane (input  base_pc, fire, cut, cut_lane, window);

endinterface

interface fetch_lane_if import fetch_pkg::*; ();

    addr_t pc;
    addr_t npc;
    inst_t inst;
    logic  valid;

    modport lane  (output pc, npc, inst, valid);
    modport queue (input  pc, npc, inst, valid);

endinterface

`default_nettype wire

// ==== src/fetch_pkg.sv ====
// Shared types of the fetch front end
// Addresses, instruction words, cache blocks and window, lane index and mask

`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // Byte address
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // One instruction word
    typedef logic [31:0] inst_t;

    // One cache block, word 0 in the low half
    typedef logic [63:0] mem_block_t;

    // Cache response, block 0 at the aligned fetch address
    typedef mem_block_t [`WINDOW_BLOCKS-1:0] window_t;

    // Lane index, kept at least one bit wide for a single-lane build
    localparam int unsigned LANE_IDX_W = (`FETCH_WIDTH > 1) ? $clog2(`FETCH_WIDTH) : 1;
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    // One bit per lane
    typedef logic [`FETCH_WIDTH-1:0] lane_mask_t;

endpackage

`default_nettype wire

// ==== src/fetch_defs.svh ====
// Fetch front-end configuration macros
// Bundle width, address width, reset PC, NOP word, cache window, queue depth

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Lanes per bundle, a power of two from 1 to 4
`define FETCH_WIDTH 2

// Byte address width
`define ADDR_WIDTH 32

// Fetch PC after reset
`define RESET_PC 32'h0000_0000

// Word driven on lanes that carry no instruction
`define NOP 32'h0000_0013

// 64-bit blocks returned by the cache, one extra so an unaligned bundle fits
`define WINDOW_BLOCKS (`FETCH_WIDTH / 2 + 1)

// Bundle entries in the dispatch queue, a power of two
`define QUEUE_DEPTH 4

`endif
